//--- sources.f
hw/conv_pkg.sv
hw/cmd_decoder.sv
hw/filter_bank.sv
hw/window_buffer.sv
hw/mac_array.sv
hw/output_accum.sv
hw/conv_cfu.sv
dv/conv_cfu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module conv_cfu_tb \
	-f sources.f -Mdir obj_dir -o conv_sim; then
	echo "Verilator compile failed"
	exit 1
fi

output=$(./obj_dir/conv_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test passed" <<< "$output"; then
	exit 0
fi
exit 1

//--- dv/conv_cfu_tb.sv
`timescale 1ns/1ps

module conv_cfu_tb import conv_pkg::*; ();

	logic clk;
	logic reset;
	logic cmd_valid;
	logic cmd_ready;
	logic [FID_W-1:0] function_id;
	logic [DATA_W-1:0] in0;
	logic [DATA_W-1:0] in1;
	logic rsp_valid;
	logic rsp_ready;
	logic [DATA_W-1:0] rsp_data;

	// Model of the unit state
	logic [TAP_W-1:0] m_filt [TAPS];
	logic [TAP_W-1:0] m_win [TAPS];
	int m_off;
	logic [DATA_W-1:0] m_result;
	logic [DATA_W-1:0] m_out [OUT_DIM][OUT_DIM];

	logic [DATA_W-1:0] expected [$];
	int errors;
	int cmds_sent;
	int cycles;

	conv_cfu dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [DATA_W-1:0] conv_dot();
		int sum;
		int p;
		shortint p16;
		byte wb;
		byte fb;
		sum = 0;
		for (int t = 0; t < TAPS; t++) begin
			for (int l = 0; l < LANES; l++) begin
				wb = byte'(m_win[t][l*LANE_W +: LANE_W]);
				fb = byte'(m_filt[t][l*LANE_W +: LANE_W]);
				p = (int'(wb) + m_off) * int'(fb);
				// Low 16 bits only, kept signed
				p16 = shortint'(p);
				sum += int'(p16);
			end
		end
		return sum;
	endfunction

	function automatic void check_value(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] want);
		assert (got === want) else begin
			errors++;
			$display("ERROR %0t %s: got %h, expected %h", $time, name, got, want);
		end
	endfunction

	// Checked every cycle it is valid, leaves after a cycle with ready high
	always @(negedge clk) begin
		if (!reset && rsp_valid) begin
			assert (expected.size() > 0) else begin
				errors++;
				$display("A response arrived at %0t with no command outstanding", $time);
			end
			if (expected.size() > 0) begin
				check_value("rsp_data", rsp_data, expected[0]);
				if (rsp_ready) begin
					expected.delete(0);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > 200 * cmds_sent + 500) begin
			$display("Run stopped after %0d cycles, a command or response never completed", cycles);
			$display("Test failed");
			$finish;
		end
	end

	task automatic drive_cmd(input logic [FID_W-1:0] fid, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] exp_val, input logic ready_now);
		@(posedge clk);
		#1;
		cmd_valid = 1'b1;
		function_id = fid;
		in0 = a;
		in1 = b;
		rsp_ready = ready_now;
		expected.push_back(exp_val);
		cmds_sent++;
	endtask

	task automatic wait_accept();
		@(negedge clk);
		while (!cmd_ready) @(negedge clk);
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
		check_value("rsp_valid", rsp_valid, 1);
	endtask

	task automatic take_rsp(input logic ready_now);
		int stall;
		stall = ready_now ? 0 : $urandom_range(0, 3);
		repeat (stall) begin
			@(posedge clk);
			#1;
		end
		rsp_ready = 1'b1;
		@(negedge clk);
		while (!(rsp_valid && rsp_ready)) @(negedge clk);
		@(posedge clk);
		#1;
		rsp_ready = 1'b0;
	endtask

	task automatic send(input logic [FID_W-1:0] fid, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] exp_val);
		logic ready_now;
		ready_now = ($urandom_range(0, 1) == 1);
		drive_cmd(fid, a, b, exp_val, ready_now);
		wait_accept();
		take_rsp(ready_now);
	endtask

	function automatic logic [TAP_W-1:0] rand_tap();
		return {$urandom(), $urandom()};
	endfunction

	task automatic load_tap(input logic win_sel, input int t, input logic [TAP_W-1:0] v);
		logic [GROUP_W-1:0] grp;
		logic [OP_W-1:0] op;
		grp = win_sel ? GRP_WIN : GRP_FILT;
		op = OP_W'(t);
		if (t == TAPS - 1) begin
			grp = win_sel ? GRP_WIN_HI : GRP_FILT_HI;
			op = OP_TAP_HI;
		end
		send({grp, op}, v[DATA_W-1:0], v[TAP_W-1:DATA_W], '0);
		if (win_sel) m_win[t] = v;
		else m_filt[t] = v;
	endtask

	task automatic slide_row(input int r, input logic [TAP_W-1:0] v);
		send({GRP_WIN_HI, OP_SLIDE0 + OP_W'(r)}, v[DATA_W-1:0], v[TAP_W-1:DATA_W], '0);
		m_win[3*r] = m_win[3*r + 1];
		m_win[3*r + 1] = m_win[3*r + 2];
		m_win[3*r + 2] = v;
	endtask

	task automatic do_compute();
		m_result = conv_dot();
		send({GRP_CTRL, OP_COMPUTE}, '0, '0, m_result);
	endtask

	task automatic accum(input int r, input int c);
		send({GRP_OUT, OP_ACCUM}, r, c, '0);
		m_out[r][c] += m_result;
	endtask

	task automatic read_entry(input int r, input int c);
		send({GRP_OUT, OP_READ}, r, c, m_out[r][c]);
		m_out[r][c] = '0;
	endtask

	function automatic void zero_out_model();
		for (int r = 0; r < OUT_DIM; r++) begin
			for (int c = 0; c < OUT_DIM; c++) m_out[r][c] = '0;
		end
	endfunction

	initial begin
		int row_q [$];
		int col_q [$];
		int r;
		int c;
		int held_off;
		void'($urandom(96));
		errors = 0;
		cmds_sent = 0;
		cycles = 0;
		reset = 1'b1;
		cmd_valid = 1'b0;
		function_id = '0;
		in0 = '0;
		in1 = '0;
		rsp_ready = 1'b0;
		m_off = 0;
		m_result = '0;
		for (int t = 0; t < TAPS; t++) begin
			m_filt[t] = '0;
			m_win[t] = '0;
		end
		zero_out_model();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		@(negedge clk);
		check_value("cmd_ready", cmd_ready, 1);
		check_value("rsp_valid", rsp_valid, 0);
		send({GRP_CTRL, OP_NOP}, '0, '0, '0);

		// Full load, then one compute
		for (int t = 0; t < TAPS; t++) load_tap(1'b0, t, rand_tap());
		for (int t = 0; t < TAPS; t++) load_tap(1'b1, t, rand_tap());
		m_off = int'($urandom_range(0, 255)) - 128;
		send({GRP_CTRL, OP_SET_OFFSET}, m_off, '0, '0);
		do_compute();

		repeat (4) begin
			slide_row($urandom_range(0, 2), rand_tap());
			do_compute();
		end

		// Accumulate with some repeated entries
		send({GRP_OUT, OP_CLEAR}, '0, '0, '0);
		zero_out_model();
		for (int k = 0; k < 6; k++) begin
			load_tap(1'b1, $urandom_range(0, TAPS - 1), rand_tap());
			do_compute();
			r = $urandom_range(0, OUT_DIM - 1);
			c = $urandom_range(0, OUT_DIM - 1);
			if (k % 3 == 2) begin
				r = row_q[$];
				c = col_q[$];
			end
			accum(r, c);
			row_q.push_back(r);
			col_q.push_back(c);
		end
		read_entry(row_q[0], col_q[0]);
		read_entry(row_q[0], col_q[0]);
		read_entry(row_q[2], col_q[2]);
		read_entry(row_q[2], col_q[2]);
		send({GRP_OUT, OP_CLEAR}, '0, '0, '0);
		zero_out_model();
		foreach (row_q[i]) read_entry(row_q[i], col_q[i]);

		// Stall the response while the next command waits
		m_result = conv_dot();
		drive_cmd({GRP_CTRL, OP_COMPUTE}, '0, '0, m_result, 1'b0);
		wait_accept();
		held_off = int'($urandom_range(0, 255)) - 128;
		drive_cmd({GRP_CTRL, OP_SET_OFFSET}, held_off, '0, '0, 1'b0);
		repeat (5) begin
			@(negedge clk);
			check_value("rsp_data", rsp_data, m_result);
			check_value("cmd_ready", cmd_ready, 0);
		end
		@(posedge clk);
		#1;
		take_rsp(1'b1);
		check_value("rsp_valid", rsp_valid, 0);
		wait_accept();
		m_off = held_off;
		take_rsp(1'b0);
		do_compute();

		repeat (2) @(posedge clk);
		$display("Errors: %0d", errors);
		if (errors == 0) $display("Test passed");
		else $display("Test failed");
		$finish;
	end

endmodule

//--- hw/conv_cfu.sv
`timescale 1ns/1ps

module conv_cfu import conv_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic               cmd_valid,
	output logic               cmd_ready,
	input  logic [FID_W-1:0]   function_id,
	input  logic [DATA_W-1:0]  in0,
	input  logic [DATA_W-1:0]  in1,
	output logic               rsp_valid,
	input  logic               rsp_ready,
	output logic [DATA_W-1:0]  rsp_data
);

	logic filter_we;
	logic window_we;
	logic window_slide;
	logic offset_we;
	logic compute;
	logic out_clear;
	logic out_accum;
	logic out_read;
	logic [TAP_IDX_W-1:0] tap_idx;
	logic [TAPS*TAP_W-1:0] filter;
	logic [TAPS*TAP_W-1:0] window;
	logic [DATA_W-1:0] dot_sum;
	logic [DATA_W-1:0] result;
	logic [DATA_W-1:0] read_data;

	cmd_decoder u_dec (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.function_id(function_id),
		.cmd_ready(cmd_ready),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp_data(rsp_data),
		.dot_sum(dot_sum),
		.read_data(read_data),
		.filter_we(filter_we),
		.window_we(window_we),
		.window_slide(window_slide),
		.offset_we(offset_we),
		.compute(compute),
		.out_clear(out_clear),
		.out_accum(out_accum),
		.out_read(out_read),
		.tap_idx(tap_idx)
	);

	filter_bank u_filt (
		.clk(clk),
		.reset(reset),
		.filter_we(filter_we),
		.tap_idx(tap_idx),
		.in0(in0),
		.in1(in1),
		.filter(filter)
	);

	window_buffer u_win (
		.clk(clk),
		.reset(reset),
		.window_we(window_we),
		.window_slide(window_slide),
		.tap_idx(tap_idx),
		.in0(in0),
		.in1(in1),
		.window(window)
	);

	mac_array u_mac (
		.clk(clk),
		.reset(reset),
		.offset_we(offset_we),
		.compute(compute),
		.in0(in0),
		.filter(filter),
		.window(window),
		.dot_sum(dot_sum),
		.result(result)
	);

	output_accum u_out (
		.clk(clk),
		.reset(reset),
		.out_clear(out_clear),
		.out_accum(out_accum),
		.out_read(out_read),
		.in0(in0),
		.in1(in1),
		.result(result),
		.read_data(read_data)
	);

endmodule

//--- hw/output_accum.sv
`timescale 1ns/1ps

module output_accum import conv_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic               out_clear,
	input  logic               out_accum,
	input  logic               out_read,
	input  logic [DATA_W-1:0]  in0,
	input  logic [DATA_W-1:0]  in1,
	input  logic [DATA_W-1:0]  result,
	output logic [DATA_W-1:0]  read_data
);

	logic [DATA_W-1:0] mem [OUT_DIM][OUT_DIM];
	logic [OUT_IDX_W-1:0] row;
	logic [OUT_IDX_W-1:0] col;
	logic in_range;

	assign row = in0[OUT_IDX_W-1:0];
	assign col = in1[OUT_IDX_W-1:0];
	assign in_range = (in0 < OUT_DIM) && (in1 < OUT_DIM);

	// Coordinates off the file read as zero
	assign read_data = in_range ? mem[row][col] : '0;

	always_ff @(posedge clk) begin
		if (reset || out_clear) begin
			for (int r = 0; r < OUT_DIM; r++) begin
				for (int c = 0; c < OUT_DIM; c++) begin
					mem[r][c] <= '0;
				end
			end
		end else if (in_range) begin
			if (out_accum) begin
				mem[row][col] <= mem[row][col] + result;
			end else if (out_read) begin
				// Entry is handed out and emptied in one step
				mem[row][col] <= '0;
			end
		end
	end

	a_coord_range: assert property (@(posedge clk) disable iff (reset)
		(out_accum || out_read) |-> in_range);

endmodule

//--- hw/mac_array.sv
`timescale 1ns/1ps

module mac_array import conv_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   offset_we,
	input  logic                   compute,
	input  logic [DATA_W-1:0]      in0,
	input  logic [TAPS*TAP_W-1:0]  filter,
	input  logic [TAPS*TAP_W-1:0]  window,
	output logic [DATA_W-1:0]      dot_sum,
	output logic [DATA_W-1:0]      result
);

	logic signed [DATA_W-1:0] offset;
	logic signed [PROD_W-1:0] prod [TAPS*LANES];
	logic signed [DATA_W-1:0] tap_sum [TAPS];
	logic signed [DATA_W-1:0] total;

	always_ff @(posedge clk) begin
		if (reset) begin
			offset <= '0;
			result <= '0;
		end else begin
			if (offset_we) begin
				offset <= in0;
			end
			if (compute) begin
				result <= dot_sum;
			end
		end
	end

	// One multiplier per channel of each tap
	for (genvar p = 0; p < TAPS*LANES; p++) begin : g_lane
		logic signed [LANE_W-1:0] w_byte;
		logic signed [LANE_W-1:0] f_byte;
		logic signed [DATA_W-1:0] w_ext;
		logic signed [DATA_W-1:0] f_ext;
		logic signed [DATA_W-1:0] full;

		assign w_byte = window[p*LANE_W +: LANE_W];
		assign f_byte = filter[p*LANE_W +: LANE_W];
		assign w_ext = w_byte;
		assign f_ext = f_byte;
		assign full = (w_ext + offset) * f_ext;
		assign prod[p] = full[PROD_W-1:0];
	end

	// Per-tap lane sums, then the taps
	always_comb begin
		total = '0;
		for (int t = 0; t < TAPS; t++) begin
			tap_sum[t] = '0;
			for (int l = 0; l < LANES; l++) begin
				tap_sum[t] = tap_sum[t] + prod[t*LANES + l];
			end
			total = total + tap_sum[t];
		end
	end

	assign dot_sum = total;

endmodule

//--- hw/window_buffer.sv
`timescale 1ns/1ps

module window_buffer import conv_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   window_we,
	input  logic                   window_slide,
	input  logic [TAP_IDX_W-1:0]   tap_idx,
	input  logic [DATA_W-1:0]      in0,
	input  logic [DATA_W-1:0]      in1,
	output logic [TAPS*TAP_W-1:0]  window
);

	logic [TAP_W-1:0] taps [TAPS];
	logic [TAP_W-1:0] new_tap;

	assign new_tap = {in1, in0};

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int t = 0; t < TAPS; t++) begin
				taps[t] <= '0;
			end
		end else if (window_we) begin
			taps[tap_idx] <= new_tap;
		end else if (window_slide) begin
			// Shift the row one column left, new tap enters on the right
			for (int r = 0; r < KDIM; r++) begin
				if (tap_idx == TAP_IDX_W'(r)) begin
					taps[KDIM*r] <= taps[KDIM*r + 1];
					taps[KDIM*r + 1] <= taps[KDIM*r + 2];
					taps[KDIM*r + 2] <= new_tap;
				end
			end
		end
	end

	for (genvar t = 0; t < TAPS; t++) begin : g_flat
		assign window[t*TAP_W +: TAP_W] = taps[t];
	end

	a_slide_row: assert property (@(posedge clk) disable iff (reset)
		window_slide |-> tap_idx < KDIM);

endmodule

//--- hw/filter_bank.sv
`timescale 1ns/1ps

module filter_bank import conv_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   filter_we,
	input  logic [TAP_IDX_W-1:0]   tap_idx,
	input  logic [DATA_W-1:0]      in0,
	input  logic [DATA_W-1:0]      in1,
	output logic [TAPS*TAP_W-1:0]  filter
);

	logic [TAP_W-1:0] taps [TAPS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int t = 0; t < TAPS; t++) begin
				taps[t] <= '0;
			end
		end else if (filter_we) begin
			// in0 holds lanes 0..3
			taps[tap_idx] <= {in1, in0};
		end
	end

	for (genvar t = 0; t < TAPS; t++) begin : g_flat
		assign filter[t*TAP_W +: TAP_W] = taps[t];
	end

	a_tap_range: assert property (@(posedge clk) disable iff (reset)
		filter_we |-> tap_idx < TAPS);

endmodule

//--- hw/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder import conv_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 cmd_valid,
	input  logic [FID_W-1:0]     function_id,
	output logic                 cmd_ready,
	output logic                 rsp_valid,
	input  logic                 rsp_ready,
	output logic [DATA_W-1:0]    rsp_data,
	input  logic [DATA_W-1:0]    dot_sum,
	input  logic [DATA_W-1:0]    read_data,
	output logic                 filter_we,
	output logic                 window_we,
	output logic                 window_slide,
	output logic                 offset_we,
	output logic                 compute,
	output logic                 out_clear,
	output logic                 out_accum,
	output logic                 out_read,
	output logic [TAP_IDX_W-1:0] tap_idx
);

	logic [GROUP_W-1:0] grp;
	logic [OP_W-1:0] op;
	logic accept;
	logic [DATA_W-1:0] rsp_next;

	assign {grp, op} = function_id;

	// Busy while a response waits for the CPU
	assign cmd_ready = ~rsp_valid;
	assign accept = cmd_valid & cmd_ready;

	always_comb begin
		filter_we = 1'b0;
		window_we = 1'b0;
		window_slide = 1'b0;
		offset_we = 1'b0;
		compute = 1'b0;
		out_clear = 1'b0;
		out_accum = 1'b0;
		out_read = 1'b0;
		tap_idx = TAP_IDX_W'(op);
		case (grp)
			GRP_CTRL: begin
				case (op)
					OP_NOP: ;
					OP_SET_OFFSET: offset_we = accept;
					OP_COMPUTE: compute = accept;
					default: ;
				endcase
			end
			GRP_FILT: filter_we = accept;
			GRP_FILT_HI: begin
				filter_we = accept && (op == OP_TAP_HI);
				tap_idx = TAP_IDX_W'(TAPS - 1);
			end
			GRP_OUT: begin
				out_clear = accept && (op == OP_CLEAR);
				out_accum = accept && (op == OP_ACCUM);
				out_read = accept && (op == OP_READ);
			end
			GRP_WIN: window_we = accept;
			GRP_WIN_HI: begin
				if (op == OP_TAP_HI) begin
					window_we = accept;
					tap_idx = TAP_IDX_W'(TAPS - 1);
				end else if (op >= OP_SLIDE0 && op < OP_SLIDE0 + KDIM) begin
					// Index carries the kernel row
					window_slide = accept;
					tap_idx = TAP_IDX_W'(op - OP_SLIDE0);
				end
			end
			default: ;
		endcase
	end

	assign rsp_next = compute ? dot_sum : (out_read ? read_data : '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid <= 1'b0;
			rsp_data <= '0;
		end else if (accept) begin
			rsp_valid <= 1'b1;
			rsp_data <= rsp_next;
		end else if (rsp_ready) begin
			rsp_valid <= 1'b0;
		end
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (reset)
		$onehot0({filter_we, window_we, window_slide, offset_we,
			compute, out_clear, out_accum, out_read}));

	a_rsp_stable: assert property (@(posedge clk) disable iff (reset)
		rsp_valid && !rsp_ready |=> $stable(rsp_data));

endmodule

//--- hw/conv_pkg.sv
package conv_pkg;

	// Command word layout
	localparam int DATA_W = 32;
	localparam int FID_W = 10;
	localparam int GROUP_W = 7;
	localparam int OP_W = 3;

	// One tap holds a signed byte per channel
	localparam int LANES = 8;
	localparam int LANE_W = 8;
	localparam int TAP_W = LANES * LANE_W;

	// 3x3 kernel, tap t is row t/3, column t%3
	localparam int KDIM = 3;
	localparam int TAPS = KDIM * KDIM;
	localparam int TAP_IDX_W = 4;

	// Products are cut down to 16 bits before the sum
	localparam int PROD_W = 16;

	// Output register file
	localparam int OUT_DIM = 28;
	localparam int OUT_IDX_W = 5;

	// Function-id groups (upper field)
	localparam logic [GROUP_W-1:0] GRP_CTRL = 7'd0;
	localparam logic [GROUP_W-1:0] GRP_FILT = 7'd1;
	localparam logic [GROUP_W-1:0] GRP_FILT_HI = 7'd2;
	localparam logic [GROUP_W-1:0] GRP_OUT = 7'd3;
	localparam logic [GROUP_W-1:0] GRP_WIN = 7'd4;
	localparam logic [GROUP_W-1:0] GRP_WIN_HI = 7'd5;

	// GRP_CTRL ops
	localparam logic [OP_W-1:0] OP_NOP = 3'd0;
	localparam logic [OP_W-1:0] OP_SET_OFFSET = 3'd1;
	localparam logic [OP_W-1:0] OP_COMPUTE = 3'd2;

	// GRP_OUT ops
	localparam logic [OP_W-1:0] OP_CLEAR = 3'd0;
	localparam logic [OP_W-1:0] OP_ACCUM = 3'd1;
	localparam logic [OP_W-1:0] OP_READ = 3'd2;

	// GRP_FILT_HI and GRP_WIN_HI ops
	localparam logic [OP_W-1:0] OP_TAP_HI = 3'd0;
	// Slides of rows 0..2 follow on from here
	localparam logic [OP_W-1:0] OP_SLIDE0 = 3'd1;

endpackage
